/* verilog/pipe_consts.svh */
// queue depth must be a power of two; any opcode not listed below decodes as illegal
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

`define PIPE_XLEN      32       // instruction word and address width
`define PIPE_REG_W     5        // register index width
`define PIPE_CAUSE_W   4        // trap cause width
`define PIPE_QDEPTH    4        // instruction queue entries

// micro-op field positions
`define OPC_HI         31
`define OPC_LO         28
`define RD_HI          27
`define RD_LO          23
`define RS1_HI         22
`define RS1_LO         18
`define RS2_HI         17
`define RS2_LO         13
`define IMM_HI         12
`define IMM_LO         0

// opcodes
`define OP_ALU         4'h1
`define OP_LOAD        4'h2
`define OP_STORE       4'h3
`define OP_JUMP        4'h4
`define OP_HALT        4'hf

`define TRAP_VECTOR    32'h100
`define CAUSE_ILLEGAL  4'd2

`endif

/* verilog/pipe_types_pkg.sv */
// types shared by the pipeline blocks; widths come from the consts header
`include "pipe_consts.svh"

package pipe_types_pkg;

    // instruction word or byte address
    typedef logic [`PIPE_XLEN-1:0]    word_t;

    // register index, 0 = no destination
    typedef logic [`PIPE_REG_W-1:0]   reg_idx_t;

    // trap cause code
    typedef logic [`PIPE_CAUSE_W-1:0] cause_t;

    // op held in the memory stage register
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,   // bubble or halt
        MEM_ALU   = 2'd1,   // alu and jump, complete at once
        MEM_LOAD  = 2'd2,
        MEM_STORE = 2'd3
    } mem_op_t;

endpackage

/* verilog/fetch_stage.sv */
// PC resets to 0; instruction memory is word addressed by PC and answers when busy is low
`timescale 1ns/100ps

module fetch_stage import pipe_types_pkg::*; (
    input  logic  CLK,
    input  logic  rst_n,
    input  logic  pc_en,        // hazard unit lets the PC move
    input  logic  npc_sel,      // jump redirect
    input  logic  if_ex_flush,  // drop the word in flight
    input  logic  insert_pc,    // trap entry
    input  word_t jump_target,
    input  word_t priv_pc,
    input  logic  imem_busy,
    input  word_t imem_rdata,
    output word_t imem_addr,
    output logic  imem_ren,
    output word_t fetch_pc,
    output word_t fetch_word,
    output logic  fetch_valid
);

    word_t pc;
    logic  accept;   // word handed over this cycle

    // no request while a flush is pending, the word would be thrown away
    assign imem_ren  = !if_ex_flush;
    assign imem_addr = pc;
    assign accept    = imem_ren && !imem_busy;

    // straight into the queue, written at the next edge
    assign fetch_pc    = pc;
    assign fetch_word  = imem_rdata;
    assign fetch_valid = accept && pc_en;   // pc_en low means queue can't take it

    // next pc: trap vector, then jump, then sequential
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_en) begin
            if (insert_pc) begin
                pc <= priv_pc;
            end else if (npc_sel) begin
                pc <= jump_target;
            end else if (accept) begin
                pc <= pc + 32'd4;   // only step past a word we kept
            end
        end
    end

endmodule

/* verilog/insn_queue.sv */
// circular buffer of PC/word pairs, depth from PIPE_QDEPTH (power of two); flush beats a write
`timescale 1ns/100ps
`include "pipe_consts.svh"

module insn_queue import pipe_types_pkg::*; (
    input  logic  CLK,
    input  logic  rst_n,
    input  logic  fetch_valid,
    input  word_t fetch_pc,
    input  word_t fetch_word,
    input  logic  stall_queue,   // hold the head
    input  logic  flush_queue,   // empty in one cycle
    output logic  queue_valid,
    output word_t pc_e,
    output word_t word_e,
    output logic  is_queue_full
);

    localparam int PTR_W = $clog2(`PIPE_QDEPTH);

    word_t pc_mem   [`PIPE_QDEPTH];   // payload, no reset
    word_t word_mem [`PIPE_QDEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;      // one extra bit so full is representable
    logic             push;
    logic             pop;

    assign queue_valid   = (count != '0);
    assign is_queue_full = (count == (PTR_W+1)'(`PIPE_QDEPTH));

    assign push = fetch_valid && !is_queue_full;
    assign pop  = queue_valid && !stall_queue;   // head leaves on every free cycle

    assign pc_e   = pc_mem[rd_ptr];
    assign word_e = word_mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (push) begin
            pc_mem[wr_ptr]   <= fetch_pc;
            word_mem[wr_ptr] <= fetch_word;
        end
    end

    // pointers wrap naturally with a power of two depth
    always_ff @(posedge CLK) begin
        if (!rst_n || flush_queue) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

endmodule

/* verilog/stage3_hazard_unit.sv */
// no forwarding of load data; only illegal opcodes raise exceptions; iren is treated as always asked
`timescale 1ns/100ps
`include "pipe_consts.svh"

module stage3_hazard_unit import pipe_types_pkg::*; (
    input  logic     queue_valid,
    input  word_t    pc_e,
    input  word_t    word_e,
    input  word_t    fetch_pc,
    input  reg_idx_t rd_m,
    input  mem_op_t  op_m,
    input  logic     valid_m,
    input  logic     imem_busy,
    input  logic     dmem_busy,
    input  logic     halt_m,
    input  logic     is_queue_full,
    input  logic     insert_pc,
    output logic     pc_en,
    output logic     npc_sel,
    output logic     if_ex_flush,
    output logic     stall_queue,
    output logic     flush_queue,
    output logic     ex_mem_stall,
    output logic     ex_mem_flush,
    output logic     exception,
    output word_t    jump_target,
    output word_t    epc,
    output cause_t   cause
);

    // head decode
    logic [3:0] opcode_e;
    reg_idx_t   rs1_e;
    reg_idx_t   rs2_e;
    word_t      imm_e;
    logic       is_jump;
    logic       illegal_e;

    // hazard terms
    logic dmem_access;
    logic wait_for_imem;
    logic wait_for_dmem;
    logic rs1_match;
    logic rs2_match;
    logic cannot_forward;
    logic mem_use_stall;
    logic head_blocked;
    logic branch_jump;

    assign opcode_e = word_e[`OPC_HI:`OPC_LO];
    assign rs1_e    = word_e[`RS1_HI:`RS1_LO];
    assign rs2_e    = word_e[`RS2_HI:`RS2_LO];
    assign imm_e    = {{(`PIPE_XLEN-`IMM_HI-1){word_e[`IMM_HI]}}, word_e[`IMM_HI:`IMM_LO]};

    assign is_jump   = (opcode_e == `OP_JUMP);
    assign illegal_e = !(opcode_e inside {`OP_ALU, `OP_LOAD, `OP_STORE, `OP_JUMP, `OP_HALT});

    // source match against the memory stage, r0 never a dependency
    assign rs1_match      = (rs1_e == rd_m) && (rd_m != '0);
    assign rs2_match      = (rs2_e == rd_m) && (rd_m != '0);
    assign cannot_forward = (op_m == MEM_LOAD);   // load value only exists after mem
    assign mem_use_stall  = queue_valid && valid_m && cannot_forward && (rs1_match || rs2_match);

    assign dmem_access   = valid_m && ((op_m == MEM_LOAD) || (op_m == MEM_STORE));
    assign wait_for_dmem = dmem_access && dmem_busy;
    assign wait_for_imem = imem_busy;

    // mem stage slow or halted: everyone holds
    assign ex_mem_stall = wait_for_dmem || halt_m;

    // head can't leave the queue this cycle
    assign head_blocked = ex_mem_stall || mem_use_stall;
    assign stall_queue  = head_blocked;

    // jump leaves the head and redirects at the next edge
    assign branch_jump = queue_valid && is_jump && !head_blocked;
    assign npc_sel     = branch_jump;
    assign jump_target = pc_e + {imm_e[`PIPE_XLEN-1:2], 2'b00};   // word aligned

    // illegal head traps only once older ops are done; none during trap entry
    assign exception = queue_valid && illegal_e && !head_blocked && !insert_pc;
    assign cause     = `CAUSE_ILLEGAL;

    // oldest valid stage, the head in practice
    assign epc = queue_valid ? pc_e : fetch_pc;

    // younger words are wrong path on jump, trap or trap entry
    assign if_ex_flush = branch_jump || exception || insert_pc;
    assign flush_queue = branch_jump || exception || insert_pc;

    // bubble into mem on load-use or in place of the faulting op
    assign ex_mem_flush = (exception || mem_use_stall) && !ex_mem_stall;

    // pc moves when the queue has room and nothing downstream holds,
    // or when it is forced somewhere else
    assign pc_en = (!is_queue_full && !wait_for_imem && !ex_mem_stall)
                || branch_jump
                || insert_pc;

endmodule

/* verilog/exec_mem_stage.sv */
// load/store address is the sign-extended immediate; halt holds the stage forever and never retires
`timescale 1ns/100ps
`include "pipe_consts.svh"

module exec_mem_stage import pipe_types_pkg::*; (
    input  logic     CLK,
    input  logic     rst_n,
    input  logic     ex_mem_stall,
    input  logic     ex_mem_flush,
    input  logic     queue_valid,
    input  word_t    pc_e,
    input  word_t    word_e,
    input  logic     dmem_busy,
    output reg_idx_t rd_m,
    output mem_op_t  op_m,
    output logic     valid_m,
    output logic     halt_m,
    output word_t    pc_m,
    output word_t    dmem_addr,
    output logic     dmem_ren,
    output logic     dmem_wen,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_rd
);

    logic [3:0] opcode_e;
    mem_op_t    op_e;
    logic       known_e;   // opcode decodes to something
    word_t      addr_m;

    assign opcode_e = word_e[`OPC_HI:`OPC_LO];

    always_comb begin
        known_e = 1'b1;
        case (opcode_e)
            `OP_ALU, `OP_JUMP: op_e = MEM_ALU;   // jump completes like alu
            `OP_LOAD:          op_e = MEM_LOAD;
            `OP_STORE:         op_e = MEM_STORE;
            `OP_HALT:          op_e = MEM_NONE;
            default: begin
                op_e    = MEM_NONE;
                known_e = 1'b0;   // illegal never enters mem
            end
        endcase
    end

    // control part of the mem register
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_m <= 1'b0;
            op_m    <= MEM_NONE;
            rd_m    <= '0;
            halt_m  <= 1'b0;
        end else if (!ex_mem_stall) begin
            if (ex_mem_flush || !queue_valid || !known_e) begin
                valid_m <= 1'b0;      // bubble
                op_m    <= MEM_NONE;
                rd_m    <= '0;
                halt_m  <= 1'b0;
            end else begin
                valid_m <= 1'b1;
                op_m    <= op_e;
                rd_m    <= (op_e == MEM_STORE) ? '0 : word_e[`RD_HI:`RD_LO];  // store writes nothing
                halt_m  <= (opcode_e == `OP_HALT);
            end
        end
    end

    // payload part
    always_ff @(posedge CLK) begin
        if (!ex_mem_stall) begin
            pc_m   <= pc_e;
            addr_m <= {{(`PIPE_XLEN-`IMM_HI-1){word_e[`IMM_HI]}}, word_e[`IMM_HI:`IMM_LO]};
        end
    end

    assign dmem_addr = addr_m;
    assign dmem_ren  = valid_m && (op_m == MEM_LOAD);
    assign dmem_wen  = valid_m && (op_m == MEM_STORE);

    // retire on the completing cycle; loads/stores wait for busy low
    assign retire_valid = valid_m && !halt_m && (op_m != MEM_NONE)
                       && !((dmem_ren || dmem_wen) && dmem_busy);
    assign retire_pc    = pc_m;
    assign retire_rd    = rd_m;

endmodule

/* verilog/trap_unit.sv */
// trap entry only, no return; the vector is fixed at TRAP_VECTOR
`timescale 1ns/100ps
`include "pipe_consts.svh"

module trap_unit import pipe_types_pkg::*; (
    input  logic   CLK,
    input  logic   rst_n,
    input  logic   exception,
    input  word_t  epc,
    input  cause_t cause,
    output logic   insert_pc,
    output word_t  priv_pc,
    output logic   trap_valid,
    output word_t  trap_epc,
    output cause_t trap_cause
);

    logic take_trap;   // new exception accepted this cycle

    // a second exception during the pulse is dropped
    assign take_trap = exception && !trap_valid;

    // one cycle pulse after the faulting cycle
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            trap_valid <= 1'b0;
        end else begin
            trap_valid <= take_trap;
        end
    end

    // exception pc and cause, kept until the next trap
    always_ff @(posedge CLK) begin
        if (take_trap) begin
            trap_epc   <= epc;
            trap_cause <= cause;
        end
    end

    // fetch picks up the vector on the edge that ends the pulse
    assign insert_pc = trap_valid;
    assign priv_pc   = `TRAP_VECTOR;

endmodule

/* verilog/pipe_top.sv */
// single-issue core, no register file; memory ports use busy levels
`timescale 1ns/100ps

module pipe_top import pipe_types_pkg::*; (
    input  logic     CLK,
    input  logic     rst_n,
    output word_t    imem_addr,
    output logic     imem_ren,
    input  logic     imem_busy,
    input  word_t    imem_rdata,
    output word_t    dmem_addr,
    output logic     dmem_ren,
    output logic     dmem_wen,
    input  logic     dmem_busy,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_rd,
    output logic     trap_valid,
    output word_t    trap_epc,
    output cause_t   trap_cause
);

    // fetch side
    word_t    fetch_pc, fetch_word, jump_target, priv_pc;
    logic     fetch_valid, pc_en, npc_sel, if_ex_flush, insert_pc;
    // queue side
    word_t    pc_e, word_e;
    logic     queue_valid, is_queue_full, stall_queue, flush_queue;
    // mem stage and trap
    reg_idx_t rd_m;
    mem_op_t  op_m;
    word_t    epc;
    cause_t   cause;
    logic     valid_m, halt_m, ex_mem_stall, ex_mem_flush, exception;

    fetch_stage u_fetch (
        .CLK, .rst_n, .pc_en, .npc_sel, .if_ex_flush, .insert_pc,
        .jump_target, .priv_pc, .imem_busy, .imem_rdata,
        .imem_addr, .imem_ren, .fetch_pc, .fetch_word, .fetch_valid
    );

    insn_queue u_queue (
        .CLK, .rst_n, .fetch_valid, .fetch_pc, .fetch_word,
        .stall_queue, .flush_queue, .queue_valid, .pc_e, .word_e, .is_queue_full
    );

    stage3_hazard_unit u_hazard (
        .queue_valid, .pc_e, .word_e, .fetch_pc, .rd_m, .op_m, .valid_m,
        .imem_busy, .dmem_busy, .halt_m, .is_queue_full, .insert_pc,
        .pc_en, .npc_sel, .if_ex_flush, .stall_queue, .flush_queue,
        .ex_mem_stall, .ex_mem_flush, .exception, .jump_target, .epc, .cause
    );

    // memory-stage pc is visible on retire_pc
    exec_mem_stage u_exec_mem (
        .CLK, .rst_n, .ex_mem_stall, .ex_mem_flush, .queue_valid, .pc_e, .word_e,
        .dmem_busy, .rd_m, .op_m, .valid_m, .halt_m, .pc_m (),
        .dmem_addr, .dmem_ren, .dmem_wen, .retire_valid, .retire_pc, .retire_rd
    );

    trap_unit u_trap (
        .CLK, .rst_n, .exception, .epc, .cause,
        .insert_pc, .priv_pc, .trap_valid, .trap_epc, .trap_cause
    );

endmodule

/* sim/pipe_tests.svh */
// directed tests; each one resets the DUT, since a halt freezes the pipeline for good
`ifndef PIPE_TESTS_SVH
`define PIPE_TESTS_SVH

function automatic word_t mk_op(input logic [3:0] opc, input reg_idx_t rd,
                                input reg_idx_t rs1, input reg_idx_t rs2,
                                input logic [12:0] imm);
    return {opc, rd, rs1, rs2, imm};
endfunction

// walk the program from pc 0 and queue every op that must retire
task automatic build_expected();
    word_t pc;
    word_t w;
    word_t imm;
    logic  done;
    pc   = '0;
    done = 1'b0;
    for (int step = 0; step < 64 && !done; step++) begin
        w   = imem[pc[8:2]];
        imm = {{19{w[12]}}, w[12:0]};
        case (w[31:28])
            `OP_ALU, `OP_LOAD, `OP_STORE: begin
                exp_pc.push_back(pc);
                exp_rd.push_back(w[27:23]);
                pc = pc + 4;
            end
            `OP_JUMP: begin
                exp_pc.push_back(pc);
                exp_rd.push_back(w[27:23]);
                pc = pc + {imm[31:2], 2'b00};   // word aligned target
            end
            `OP_HALT: done = 1'b1;
            default:  pc = `TRAP_VECTOR;       // illegal never retires
        endcase
    end
endtask

// enter reset and fill memory with halts tagged by address
task automatic start_test(input logic rnd, input int dwait, input logic trap_exp);
    @(posedge CLK);
    rst_n <= 1'b0;
    random_busy      <= rnd;
    dmem_wait_cycles <= dwait;
    trap_expected    = trap_exp;
    trap_count       = 0;
    exp_pc.delete();
    exp_rd.delete();
    for (int i = 0; i < 128; i++) imem[i] = {`OP_HALT, 28'(i)};
endtask

task automatic release_reset();
    build_expected();
    repeat (10) @(posedge CLK);
    rst_n <= 1'b1;
    @(posedge CLK);   // first cycle out of reset
    check_flag("imem_ren", imem_ren, 1'b1);
    check_flag("retire_valid", retire_valid, 1'b0);
    check_flag("trap_valid", trap_valid, 1'b0);
    check_flag("dmem_ren", dmem_ren, 1'b0);
    check_flag("dmem_wen", dmem_wen, 1'b0);
endtask

// wait for the mem stage to start a load or store, then check the port
task automatic wait_data_access(input string name, input logic store, input word_t addr);
    int n;
    n = 0;
    while (!(store ? dmem_wen : dmem_ren) && n < 50) begin
        @(posedge CLK);
        n++;
    end
    if (!(store ? dmem_wen : dmem_ren)) begin
        abort_run($sformatf("%s: the data access never started", name));
    end else begin
        check_word("dmem_addr", dmem_addr, addr);
        check_flag(store ? "dmem_ren" : "dmem_wen", store ? dmem_ren : dmem_wen, 1'b0);
    end
endtask

task automatic wait_retired(input string name, input int traps);
    int n;
    n = 0;
    while (exp_pc.size() != 0 && n < 150) begin
        @(posedge CLK);
        n++;
    end
    if (exp_pc.size() != 0) begin
        abort_run($sformatf("%s: %0d retirements never happened", name, exp_pc.size()));
    end else begin
        repeat (20) @(posedge CLK);   // nothing more may retire after the halt
        if (trap_count != traps) abort_run($sformatf("%s: wrong number of traps", name));
    end
endtask

task automatic test_alu_stream();
    start_test(1'b0, 0, 1'b0);
    for (int i = 0; i < 10; i++) imem[i] = mk_op(`OP_ALU, reg_idx_t'(i + 1), '0, '0, '0);
    release_reset();
    wait_retired("alu stream", 0);
endtask

task automatic test_jump();
    start_test(1'b0, 0, 1'b0);
    imem[0] = mk_op(`OP_ALU, 5'd1, '0, '0, '0);
    imem[1] = mk_op(`OP_ALU, 5'd2, '0, '0, '0);
    imem[2] = mk_op(`OP_JUMP, 5'd0, '0, '0, 13'h40);   // pc 8 to 0x48
    for (int i = 3; i < 6; i++) imem[i] = mk_op(`OP_ALU, 5'd20, '0, '0, '0);  // wrong path
    imem[18] = mk_op(`OP_ALU, 5'd3, '0, '0, '0);
    imem[19] = mk_op(`OP_ALU, 5'd4, '0, '0, '0);
    release_reset();
    wait_retired("jump", 0);
endtask

task automatic test_load_use();
    start_test(1'b0, 2, 1'b0);
    imem[0] = mk_op(`OP_LOAD, 5'd3, '0, '0, 13'h20);
    imem[1] = mk_op(`OP_ALU, 5'd4, 5'd3, '0, '0);   // uses the load result
    imem[2] = mk_op(`OP_ALU, 5'd5, 5'd4, 5'd3, '0);
    release_reset();
    wait_data_access("load use", 1'b0, 32'h20);
    wait_retired("load use", 0);
endtask

task automatic test_store_busy();
    start_test(1'b0, 6, 1'b0);
    imem[0] = mk_op(`OP_ALU, 5'd1, '0, '0, '0);
    imem[1] = mk_op(`OP_STORE, 5'd0, 5'd1, 5'd2, 13'h10);
    imem[2] = mk_op(`OP_ALU, 5'd2, 5'd1, '0, '0);
    imem[3] = mk_op(`OP_ALU, 5'd3, '0, '0, '0);
    release_reset();
    wait_data_access("store busy", 1'b1, 32'h10);
    wait_retired("store busy", 0);
endtask

task automatic test_illegal_trap();
    start_test(1'b0, 0, 1'b1);
    exp_epc   = 32'h0c;
    exp_cause = `CAUSE_ILLEGAL;
    for (int i = 0; i < 3; i++) imem[i] = mk_op(`OP_ALU, reg_idx_t'(i + 1), '0, '0, '0);
    imem[3]  = mk_op(4'h7, 5'd6, '0, '0, '0);   // unused opcode
    imem[4]  = mk_op(`OP_ALU, 5'd7, '0, '0, '0);
    imem[64] = mk_op(`OP_ALU, 5'd9, '0, '0, '0); // trap vector
    release_reset();
    wait_retired("illegal trap", 1);
endtask

task automatic test_random_imem();
    start_test(1'b1, 1, 1'b0);
    imem[0] = mk_op(`OP_ALU, 5'd1, '0, '0, '0);
    imem[1] = mk_op(`OP_LOAD, 5'd5, '0, '0, 13'h40);
    imem[2] = mk_op(`OP_ALU, 5'd6, 5'd5, '0, '0);
    imem[3] = mk_op(`OP_STORE, 5'd0, 5'd6, '0, 13'h44);
    imem[4] = mk_op(`OP_ALU, 5'd7, '0, '0, '0);
    imem[5] = mk_op(`OP_LOAD, 5'd8, '0, '0, 13'h48);
    imem[6] = mk_op(`OP_ALU, 5'd9, '0, 5'd8, '0);
    for (int i = 7; i < 12; i++) imem[i] = mk_op(`OP_ALU, reg_idx_t'(i + 3), '0, '0, '0);
    imem[12] = mk_op(`OP_HALT, '0, '0, '0, '0);
    imem[13] = mk_op(`OP_ALU, 5'd15, '0, '0, '0);  // behind the halt
    release_reset();
    wait_retired("random imem", 0);
endtask

`endif

/* sim/pipe_tb.sv */
// imem model is 128 words; dmem model only delays, it holds no data; stops at the first error
`timescale 1ns/100ps
`include "pipe_consts.svh"

module pipe_tb import pipe_types_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic     CLK;
    logic     rst_n;
    logic     imem_busy;
    logic     dmem_busy;
    logic     imem_ren, dmem_ren, dmem_wen, retire_valid, trap_valid;
    word_t    imem_addr, imem_rdata, dmem_addr, retire_pc, trap_epc;
    reg_idx_t retire_rd;
    cause_t   trap_cause;

    word_t    imem [128];       // program, word index = pc / 4
    integer   seed = 18349;
    logic     random_busy;      // imem busy mode of the current test
    int       dmem_wait_cycles; // busy cycles per data access
    int       dmem_waited;
    word_t    exp_pc [$];       // expected retirements, oldest first
    reg_idx_t exp_rd [$];
    logic     trap_expected;
    word_t    exp_epc;
    cause_t   exp_cause;
    int       trap_count;
    int       error_count = 0;

    pipe_top dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;   // 8 ns period
    end

    assign imem_rdata = imem[imem_addr[8:2]];   // answers whenever busy is low
    assign dmem_busy  = (dmem_ren || dmem_wen) && (dmem_waited < dmem_wait_cycles);

    always @(posedge CLK) begin
        if (!rst_n || !dmem_busy) dmem_waited <= 0;
        else dmem_waited <= dmem_waited + 1;
        imem_busy <= random_busy ? (($random(seed) & 3) == 0) : 1'b0;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        error_count++;
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // retire monitor, in order against the walked program
    always @(posedge CLK) begin
        if (rst_n && retire_valid) begin
            if (dmem_busy) begin
                abort_run("a retirement happened while the data port was busy");
            end else if (exp_pc.size() == 0) begin
                abort_run($sformatf("unexpected retirement of pc 0x%h", retire_pc));
            end else begin
                check_word("retire_pc", retire_pc, exp_pc.pop_front());
                check_reg("retire_rd", retire_rd, exp_rd.pop_front());
            end
        end
    end

    // trap monitor
    always @(posedge CLK) begin
        if (rst_n && trap_valid) begin
            trap_count++;
            if (!trap_expected) begin
                abort_run("a trap was taken in a test without an illegal op");
            end else begin
                check_word("trap_epc", trap_epc, exp_epc);
                check_cause("trap_cause", trap_cause, exp_cause);
            end
        end
    end

    `include "pipe_tests.svh"

    // watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge CLK);
        abort_run("watchdog expired, the tests took too long");
    end

    initial begin
        rst_n            = 1'b0;
        imem_busy        = 1'b0;
        random_busy      = 1'b0;
        dmem_wait_cycles = 0;
        trap_expected    = 1'b0;
        trap_count       = 0;
        test_alu_stream();
        test_jump();
        test_load_use();
        test_store_busy();
        test_illegal_trap();
        test_random_imem();
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
+incdir+sim
verilog/pipe_types_pkg.sv
verilog/fetch_stage.sv
verilog/insn_queue.sv
verilog/stage3_hazard_unit.sv
verilog/exec_mem_stage.sv
verilog/trap_unit.sv
verilog/pipe_top.sv
sim/pipe_tb.sv
